//--- alu.sv
`timescale 1ns/10ps

module alu
    import rv_pkg::*;
(
    input  op_t   op,
    input  word_t op1,
    input  word_t op2,
    input  word_t imm,
    input  word_t pc,
    output word_t result,
    output word_t target
);

    logic [5:0] shamt;
    word_t      pc_rel;

    assign shamt  = op2[5:0]; // rv64 shift amount.
    assign pc_rel = pc + imm;

    always_comb begin
        result = '0;
        target = '0;
        case (op)
            ADD:    result = op1 + op2;
            SUB:    result = op1 - op2;
            AND_OP: result = op1 & op2;
            OR_OP:  result = op1 | op2;
            XOR_OP: result = op1 ^ op2;
            SLL:    result = op1 << shamt;
            SRL:    result = op1 >> shamt;
            SLT:    result = ($signed(op1) < $signed(op2)) ? 64'd1 : 64'd0;
            ADDI:   result = op1 + imm;
            LUI:    result = imm;
            BEQ, BNE, BLT: begin
                target = pc_rel;
            end
            JAL: begin
                result = pc + 64'd4; // link address.
                target = pc_rel;
            end
            default: begin
                result = '0;
                target = '0;
            end
        endcase
    end

endmodule

//--- decode_stage.sv
`timescale 1ns/10ps

module decode_stage
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        inst_valid,
    output logic        inst_ready,
    input  logic [31:0] inst,
    input  word_t       inst_pc,
    output reg_addr_t   rs1_addr,
    output reg_addr_t   rs2_addr,
    input  word_t       rs1_data,
    input  word_t       rs2_data,
    issue_if.producer   out
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    op_t        op;
    word_t      imm;
    id_ex_t     dec_rec;
    logic       accept;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        op  = ILLEGAL;
        imm = '0;
        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD:  op = ADD;
                        F3_SLL:  op = SLL;
                        F3_SLT:  op = SLT;
                        F3_XOR:  op = XOR_OP;
                        F3_SRL:  op = SRL;
                        F3_OR:   op = OR_OP;
                        F3_AND:  op = AND_OP;
                        default: op = ILLEGAL;
                    endcase
                end else if (funct7 == F7_ALT && funct3 == F3_ADD) begin
                    op = SUB;
                end
            end
            OPC_OP_IMM: begin
                if (funct3 == F3_ADD) begin
                    op  = ADDI;
                    imm = imm_i;
                end
            end
            OPC_LUI: begin
                op  = LUI;
                imm = imm_u;
            end
            OPC_BRANCH: begin
                imm = imm_b;
                case (funct3)
                    F3_BEQ:  op = BEQ;
                    F3_BNE:  op = BNE;
                    F3_BLT:  op = BLT;
                    default: op = ILLEGAL;
                endcase
            end
            OPC_JAL: begin
                op  = JAL;
                imm = imm_j;
            end
            default: op = ILLEGAL;
        endcase
    end

    always_comb begin
        dec_rec.op        = op;
        dec_rec.pc        = inst_pc;
        dec_rec.rs1_addr  = rs1_addr;
        dec_rec.rs2_addr  = rs2_addr;
        dec_rec.rs1_value = rs1_data;
        dec_rec.rs2_value = rs2_data;
        dec_rec.imm       = imm;
        dec_rec.rd        = inst[11:7];
        dec_rec.rd_wen    = op inside {ADD, SUB, AND_OP, OR_OP, XOR_OP, SLL, SRL, SLT,
                                       ADDI, LUI, JAL};
    end

    assign inst_ready = !out.valid || out.ready; // slot empty or being drained.
    assign accept     = inst_valid && inst_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out.valid <= 1'b0;
        end else if (accept) begin
            out.valid <= 1'b1;
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out.rec <= dec_rec;
        end
    end

endmodule

//--- ex_core_top.sv
`timescale 1ns/10ps

module ex_core_top
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        inst_valid,
    output logic        inst_ready,
    input  logic [31:0] inst,
    input  word_t       inst_pc,
    output logic        res_valid,
    input  logic        res_ready,
    output word_t       res_pc,
    output reg_addr_t   res_rd,
    output word_t       res_value,
    output logic        res_wen,
    output logic        res_jump,
    output word_t       res_target,
    output logic        res_illegal
);

    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    word_t       rs1_data;
    word_t       rs2_data;
    reg_writer_t wb;

    issue_if dec_q (.clk(clk)); // decode to queue.
    issue_if q_ex (.clk(clk));  // queue to execute.

    decode_stage decode_stage_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst_valid(inst_valid),
        .inst_ready(inst_ready),
        .inst      (inst),
        .inst_pc   (inst_pc),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .out       (dec_q.producer)
    );

    reg_file reg_file_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wr      (wb)
    );

    id_ex_queue id_ex_queue_inst (
        .clk   (clk),
        .arst_n(arst_n),
        .in    (dec_q.consumer),
        .out   (q_ex.producer)
    );

    execute execute_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .in         (q_ex.consumer),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_pc     (res_pc),
        .res_rd     (res_rd),
        .res_value  (res_value),
        .res_wen    (res_wen),
        .res_jump   (res_jump),
        .res_target (res_target),
        .res_illegal(res_illegal),
        .wb         (wb)
    );

endmodule

//--- execute.sv
`timescale 1ns/10ps

module execute
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    issue_if.consumer   in,
    output logic        res_valid,
    input  logic        res_ready,
    output word_t       res_pc,
    output reg_addr_t   res_rd,
    output word_t       res_value,
    output logic        res_wen,
    output logic        res_jump,
    output word_t       res_target,
    output logic        res_illegal,
    output reg_writer_t wb
);

    reg_writer_t forward1; // newest retired write.
    reg_writer_t forward2;
    word_t       op1;
    word_t       op2;
    word_t       alu_result;
    word_t       alu_target;
    logic        do_jump;
    logic        accept;

    function automatic word_t pick_operand(reg_addr_t addr, word_t value,
                                           reg_writer_t f1, reg_writer_t f2);
        if (f1.reg_write_enable && f1.reg_dest_addr != '0 && f1.reg_dest_addr == addr) begin
            return f1.reg_write_data;
        end
        if (f2.reg_write_enable && f2.reg_dest_addr != '0 && f2.reg_dest_addr == addr) begin
            return f2.reg_write_data;
        end
        return value;
    endfunction

    always_comb begin
        op1 = pick_operand(in.rec.rs1_addr, in.rec.rs1_value, forward1, forward2);
        op2 = pick_operand(in.rec.rs2_addr, in.rec.rs2_value, forward1, forward2);
    end

    alu alu_inst (
        .op    (in.rec.op),
        .op1   (op1),
        .op2   (op2),
        .imm   (in.rec.imm),
        .pc    (in.rec.pc),
        .result(alu_result),
        .target(alu_target)
    );

    jump_judge jump_judge_inst (
        .op     (in.rec.op),
        .op1    (op1),
        .op2    (op2),
        .do_jump(do_jump)
    );

    assign in.ready    = res_ready;
    assign accept      = in.valid && res_ready;
    assign res_valid   = in.valid;
    assign res_pc      = in.rec.pc;
    assign res_rd      = in.rec.rd;
    assign res_value   = alu_result;
    assign res_wen     = in.rec.rd_wen;
    assign res_jump    = do_jump;
    assign res_target  = alu_target;
    assign res_illegal = (in.rec.op == ILLEGAL);

    always_comb begin
        wb.reg_write_enable = accept && in.rec.rd_wen;
        wb.reg_dest_addr    = in.rec.rd;
        wb.reg_write_data   = alu_result;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            forward1 <= '0;
            forward2 <= '0;
        end else if (wb.reg_write_enable) begin
            forward1 <= wb;
            forward2 <= forward1;
        end
    end

endmodule

//--- flist.f
rv_pkg.sv
issue_if.sv
decode_stage.sv
reg_file.sv
id_ex_queue.sv
alu.sv
jump_judge.sv
execute.sv
ex_core_top.sv
tb_ex_core.sv

//--- id_ex_queue.sv
`timescale 1ns/10ps

module id_ex_queue
    import rv_pkg::*;
(
    input logic       clk,
    input logic       arst_n,
    issue_if.consumer in,
    issue_if.producer out
);

    id_ex_t     mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign out.valid = (count != 2'd0);
    assign out.rec   = mem[rd_ptr];
    assign pop       = out.valid && out.ready;
    assign in.ready  = (count != 2'd2) || pop; // full queue still takes one on a pop.
    assign push      = in.valid && in.ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in.rec;
        end
    end

endmodule

//--- issue_if.sv
`timescale 1ns/10ps

interface issue_if
    import rv_pkg::*;
(
    input logic clk
);
    logic   valid;
    logic   ready;
    id_ex_t rec;

    modport producer (
        input  clk,
        output valid,
        output rec,
        input  ready
    );

    modport consumer (
        input  clk,
        input  valid,
        input  rec,
        output ready
    );

endinterface

//--- jump_judge.sv
`timescale 1ns/10ps

module jump_judge
    import rv_pkg::*;
(
    input  op_t   op,
    input  word_t op1,
    input  word_t op2,
    output logic  do_jump
);

    always_comb begin
        case (op)
            BEQ:     do_jump = (op1 == op2);
            BNE:     do_jump = (op1 != op2);
            BLT:     do_jump = ($signed(op1) < $signed(op2));
            JAL:     do_jump = 1'b1;
            default: do_jump = 1'b0;
        endcase
    end

endmodule

//--- reg_file.sv
`timescale 1ns/10ps

module reg_file
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  reg_addr_t   rs1_addr,
    input  reg_addr_t   rs2_addr,
    output word_t       rs1_data,
    output word_t       rs2_data,
    input  reg_writer_t wr
);

    word_t regs [32];

    // a read of the register being written sees the new value.
    function automatic word_t read_port(reg_addr_t addr, word_t stored, reg_writer_t w);
        if (w.reg_write_enable && w.reg_dest_addr != '0 && w.reg_dest_addr == addr) begin
            return w.reg_write_data;
        end
        return stored;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.reg_write_enable && wr.reg_dest_addr != '0) begin
            regs[wr.reg_dest_addr] <= wr.reg_write_data; // x0 stays zero.
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_addr, regs[rs1_addr], wr);
        rs2_data = read_port(rs2_addr, regs[rs2_addr], wr);
    end

endmodule

//--- rv_pkg.sv
package rv_pkg;

    typedef logic [63:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes in inst[6:0].
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub.

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND_OP,
        OR_OP,
        XOR_OP,
        SLL,
        SRL,
        SLT,
        ADDI,
        LUI,
        BEQ,
        BNE,
        BLT,
        JAL,
        ILLEGAL
    } op_t;

    typedef struct packed {
        op_t       op;
        word_t     pc;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        word_t     rs1_value;
        word_t     rs2_value;
        word_t     imm;        // sign-extended.
        reg_addr_t rd;
        logic      rd_wen;
    } id_ex_t;

    typedef struct packed {
        logic      reg_write_enable;
        reg_addr_t reg_dest_addr;
        word_t     reg_write_data;
    } reg_writer_t;

endpackage

//--- tb_ex_core.sv
`timescale 1ns/10ps

module tb_ex_core;

    localparam int         TIMEOUT = 200; // cycles allowed per wait.
    localparam logic [6:0] OPC_OP  = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_BR  = 7'b1100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;

    typedef struct {
        logic [31:0] inst;
        logic [63:0] pc;
        logic [4:0]  rd;
        logic [63:0] value;
        logic        wen;
        logic        jump;
        logic        ctl;     // target is checked on branch and jal rows.
        logic [63:0] target;
        logic        illegal;
        int          group;
    } row_t;

    logic        clk;
    logic        arst_n;
    logic        inst_valid;
    logic        inst_ready;
    logic [31:0] inst;
    logic [63:0] inst_pc;
    logic        res_valid;
    logic        res_ready;
    logic [63:0] res_pc;
    logic [4:0]  res_rd;
    logic [63:0] res_value;
    logic        res_wen;
    logic        res_jump;
    logic [63:0] res_target;
    logic        res_illegal;

    row_t        rows[$];
    int          cur_group;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_bad;
    logic [31:0] lcg_state;
    string       group_name [7];

    ex_core_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    // addi only.
    function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, OPC_IMM};
    endfunction

    function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BR};
    endfunction

    function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic push_row(logic [31:0] w, logic [4:0] rd, logic [63:0] value, logic wen,
                            logic jump, logic ctl, logic [63:0] target, logic illegal);
        row_t r;
        r.inst    = w;
        r.pc      = 64'h1000 + 4 * rows.size();
        r.rd      = rd;
        r.value   = value;
        r.wen     = wen;
        r.jump    = jump;
        r.ctl     = ctl;
        r.target  = target;
        r.illegal = illegal;
        r.group   = cur_group;
        rows.push_back(r);
    endtask

    task automatic alu_row(logic [31:0] w, logic [4:0] rd, logic [63:0] value);
        push_row(w, rd, value, 1'b1, 1'b0, 1'b0, 64'h0, 1'b0);
    endtask

    task automatic branch_row(logic [31:0] w, logic jump, logic [63:0] target);
        push_row(w, 5'd0, 64'h0, 1'b0, jump, 1'b1, target, 1'b0);
    endtask

    task automatic jal_row(logic [31:0] w, logic [4:0] rd, logic [63:0] link,
                           logic [63:0] target);
        push_row(w, rd, link, 1'b1, 1'b1, 1'b1, target, 1'b0);
    endtask

    task automatic illegal_row(logic [31:0] w);
        push_row(w, 5'd0, 64'h0, 1'b0, 1'b0, 1'b0, 64'h0, 1'b1);
    endtask

    // pc starts at 0x1000 and steps by 4, register file starts at zero.
    task automatic build_table();
        group_name[1] = "reset state";
        group_name[2] = "immediate loads and register ops";
        group_name[3] = "dependent chains";
        group_name[4] = "branches and jal";
        group_name[5] = "x0 writes and reads";
        group_name[6] = "illegal encodings and ordering";
        cur_group = 2;
        alu_row(i_type(12'h123, 0, 1), 1, 64'h123);
        alu_row(i_type(12'hffb, 0, 2), 2, 64'hffff_ffff_ffff_fffb);
        alu_row(u_type(20'h12345, 3), 3, 64'h1234_5000);
        alu_row(u_type(20'h80000, 4), 4, 64'hffff_ffff_8000_0000);
        alu_row(r_type(7'h00, 2, 1, 3'b000, 5), 5, 64'h11e);      // add.
        alu_row(r_type(7'h20, 2, 1, 3'b000, 6), 6, 64'h128);      // sub.
        alu_row(r_type(7'h00, 6, 1, 3'b111, 7), 7, 64'h120);      // and.
        alu_row(r_type(7'h00, 1, 3, 3'b110, 8), 8, 64'h1234_5123); // or.
        alu_row(r_type(7'h00, 3, 4, 3'b100, 9), 9, 64'hffff_ffff_9234_5000);
        alu_row(r_type(7'h00, 5, 1, 3'b001, 10), 10, 64'h48_c000_0000); // sll by 30.
        alu_row(r_type(7'h00, 1, 4, 3'b101, 11), 11, 64'h1fff_ffff);    // srl by 35.
        alu_row(r_type(7'h00, 1, 2, 3'b010, 12), 12, 64'h1);      // slt with -5 < 0x123.
        alu_row(r_type(7'h00, 2, 1, 3'b010, 13), 13, 64'h0);
        cur_group = 3;
        alu_row(i_type(12'h007, 0, 14), 14, 64'h7);
        alu_row(i_type(12'h001, 14, 14), 14, 64'h8);
        alu_row(r_type(7'h00, 14, 14, 3'b000, 15), 15, 64'h10);
        alu_row(i_type(12'h003, 0, 16), 16, 64'h3);
        alu_row(r_type(7'h00, 16, 15, 3'b000, 17), 17, 64'h13);
        alu_row(r_type(7'h00, 17, 15, 3'b000, 18), 18, 64'h23);
        alu_row(r_type(7'h20, 18, 16, 3'b000, 19), 19, 64'hffff_ffff_ffff_ffe0);
        alu_row(r_type(7'h00, 17, 19, 3'b000, 20), 20, 64'hffff_ffff_ffff_fff3);
        cur_group = 4;
        branch_row(b_type(13'h0010, 1, 1, 3'b000), 1'b1, 64'h1064);
        branch_row(b_type(13'h0010, 2, 1, 3'b000), 1'b0, 64'h1068);
        branch_row(b_type(13'h1ff8, 2, 1, 3'b001), 1'b1, 64'h1054);
        branch_row(b_type(13'h0008, 0, 13, 3'b001), 1'b0, 64'h1068);
        branch_row(b_type(13'h0020, 1, 2, 3'b100), 1'b1, 64'h1084);
        branch_row(b_type(13'h0020, 2, 1, 3'b100), 1'b0, 64'h1088);
        jal_row(j_type(21'h000100, 21), 21, 64'h1070, 64'h116c);
        alu_row(i_type(12'h000, 21, 22), 22, 64'h1070);
        cur_group = 5;
        alu_row(i_type(12'h055, 1, 0), 0, 64'h178);
        alu_row(r_type(7'h00, 2, 2, 3'b000, 0), 0, 64'hffff_ffff_ffff_fff6);
        alu_row(r_type(7'h00, 0, 0, 3'b000, 23), 23, 64'h0);
        alu_row(i_type(12'h009, 0, 24), 24, 64'h9);
        jal_row(j_type(21'h1ffff0, 0), 0, 64'h1088, 64'h1074);
        alu_row(r_type(7'h00, 1, 0, 3'b000, 25), 25, 64'h123);
        cur_group = 6;
        illegal_row(32'h0000_0000);
        illegal_row(r_type(7'h01, 2, 1, 3'b000, 1)); // mul is not decoded.
        illegal_row(b_type(13'h0008, 0, 0, 3'b010));
        illegal_row(32'hffff_ffff);
        alu_row(r_type(7'h00, 0, 1, 3'b000, 27), 27, 64'h123);
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic report_test(int id, int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", id, group_name[id]);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", id, group_name[id], errors - errors_before);
        end
    endtask

    task automatic check_row(row_t r);
        check_value("res_pc", res_pc, r.pc);
        check_value("res_wen", res_wen, r.wen);
        if (r.wen) begin
            check_value("res_rd", res_rd, r.rd);
        end
        check_value("res_value", res_value, r.value);
        check_value("res_jump", res_jump, r.jump);
        if (r.ctl) begin
            check_value("res_target", res_target, r.target);
        end
        check_value("res_illegal", res_illegal, r.illegal);
    endtask

    task automatic feed_rows();
        int waited;
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk);
            inst_valid = 1'b1;
            inst       = rows[i].inst;
            inst_pc    = rows[i].pc;
            #1;
            waited = 0;
            while (!inst_ready && waited < TIMEOUT) begin
                @(negedge clk);
                #1;
                waited++;
            end
            if (!inst_ready) begin
                errors++;
                $display("timeout: inst_ready stayed low for row %0d", i);
                break;
            end
        end
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    task automatic collect_rows();
        int   waited;
        int   group_errors;
        logic got;
        group_errors = errors;
        for (int i = 0; i < rows.size(); i++) begin
            waited = 0;
            got    = 1'b0;
            while (!got && waited < TIMEOUT) begin
                @(negedge clk);
                lcg_state = lcg_step(lcg_state);
                res_ready = (lcg_state[31:16] % 3) != 0; // low about a third of the time.
                #1;
                if (res_valid && res_ready) begin
                    got = 1'b1;
                end else begin
                    waited++;
                end
            end
            if (!got) begin
                errors++;
                $display("timeout: no result came out for row %0d", i);
                break;
            end
            check_row(rows[i]);
            if (i + 1 < rows.size() && rows[i + 1].group != rows[i].group) begin
                report_test(rows[i].group, group_errors);
                group_errors = errors;
            end
        end
        // nothing may follow the last row.
        repeat (4) begin
            @(negedge clk);
            res_ready = 1'b1;
            #1;
            check_value("res_valid", res_valid, 1'b0);
        end
        report_test(rows[rows.size() - 1].group, group_errors);
    endtask

    initial begin
        int group_errors;
        arst_n       = 1'b0;
        inst_valid   = 1'b0;
        inst         = 32'h0;
        inst_pc      = 64'h0;
        res_ready    = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_bad    = 0;
        lcg_state    = 32'hee9be605;
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #1;
        group_errors = errors;
        check_value("res_valid", res_valid, 1'b0);
        check_value("inst_ready", inst_ready, 1'b1);
        report_test(1, group_errors);
        fork
            feed_rows();
            collect_rows();
        join
        $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
